//--- src/soc_consts.svh
//----------------------------------------
// Address map and decode slice constants
// Register index slice, timer channel count
//----------------------------------------

`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Slave decode field, upper address bits
`define SOC_DEC_MSB 31
`define SOC_DEC_LSB 17

// Decode values of the two peripherals
`define SOC_TIMER_BASE 15'h7001
`define SOC_GPIO_BASE 15'h7002

// Word register index inside a slave
`define SOC_REG_MSB 4
`define SOC_REG_LSB 2

// Compare timer channels
`define SOC_NUM_TIMERS 2

`endif

//--- src/soc_bus_pkg.sv
//----------------------------------------
// Wishbone bus types, slave selection enum
// Byte-select merge helper
//----------------------------------------

package soc_bus_pkg;

	// Classic Wishbone, 32-bit data path
	typedef logic [31:0] wb_adr_t;
	typedef logic [31:0] wb_dat_t;
	typedef logic [3:0]  wb_sel_t;

	// Decoder result
	typedef enum logic [1:0] {
		SLV_TIMER = 2'd0,
		SLV_GPIO  = 2'd1,
		SLV_NONE  = 2'd2
	} slave_sel_e;

	// Replace the selected bytes of old_val with new_val
	function automatic wb_dat_t wb_merge(wb_dat_t old_val, wb_dat_t new_val, wb_sel_t sel);
		wb_dat_t res;
		res = old_val;
		for (int i = 0; i < $bits(wb_sel_t); i++) begin
			if (sel[i]) begin
				res[8*i +: 8] = new_val[8*i +: 8];
			end
		end
		return res;
	endfunction

endpackage

//--- src/soc_periph_pkg.sv
//----------------------------------------
// Peripheral register index enums
// Timer control bit layout
//----------------------------------------

package soc_periph_pkg;

	// Timer word registers, channel in bit 2
	typedef enum logic [2:0] {
		TCR0 = 3'd0,
		CMP0 = 3'd1,
		CNT0 = 3'd2,
		TCR1 = 3'd4,
		CMP1 = 3'd5,
		CNT1 = 3'd6
	} timer_reg_e;

	// Timer control, low nibble of TCRx
	// trig is sticky, cleared by writing 1
	typedef struct packed {
		logic trig;
		logic irqen;
		logic ar;
		logic en;
	} timer_ctrl_t;

	// GPIO word registers
	typedef enum logic [2:0] {
		GPIO_IN       = 3'd0,
		GPIO_OUT      = 3'd1,
		GPIO_OE       = 3'd2,
		GPIO_IRQ_MASK = 3'd3,
		GPIO_IRQ_STAT = 3'd4
	} gpio_reg_e;

endpackage

//--- src/wb_slave_mux.sv
//----------------------------------------
// Wishbone address decoder and slave mux
// Default response for unmapped addresses
//----------------------------------------

`include "soc_consts.svh"

module wb_slave_mux
	import soc_bus_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n_i,
	// From master
	input  wb_adr_t wb_adr_i,
	input  logic    wb_cyc_i,
	input  logic    wb_stb_i,
	// Strobes to slaves
	output logic    tmr_stb_o,
	output logic    gpio_stb_o,
	// Slave responses
	input  logic    tmr_ack_i,
	input  logic    gpio_ack_i,
	input  wb_dat_t tmr_dat_i,
	input  wb_dat_t gpio_dat_i,
	// To master
	output wb_dat_t wb_dat_o,
	output logic    wb_ack_o
);

	logic [`SOC_DEC_MSB-`SOC_DEC_LSB:0] dec_field;
	slave_sel_e slv_sel;
	logic       bus_req;
	logic       none_ack;

	//----------------------------------------
	// Address decode
	//----------------------------------------
	assign dec_field = wb_adr_i[`SOC_DEC_MSB:`SOC_DEC_LSB];

	always_comb begin
		if (dec_field == `SOC_TIMER_BASE) begin
			slv_sel = SLV_TIMER;
		end else if (dec_field == `SOC_GPIO_BASE) begin
			slv_sel = SLV_GPIO;
		end else begin
			slv_sel = SLV_NONE;
		end
	end

	// Active cycle from the master
	assign bus_req = wb_cyc_i & wb_stb_i;

	// One strobe at most
	assign tmr_stb_o  = bus_req && (slv_sel == SLV_TIMER);
	assign gpio_stb_o = bus_req && (slv_sel == SLV_GPIO);

	// Unmapped access, own single-cycle ack
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			none_ack <= 1'b0;
		end else begin
			none_ack <= bus_req && (slv_sel == SLV_NONE) && !none_ack;
		end
	end

	//----------------------------------------
	// Response combining
	//----------------------------------------
	assign wb_ack_o = tmr_ack_i | gpio_ack_i | none_ack;

	// Data from whoever acked, zero otherwise
	always_comb begin
		if (tmr_ack_i) begin
			wb_dat_o = tmr_dat_i;
		end else if (gpio_ack_i) begin
			wb_dat_o = gpio_dat_i;
		end else begin
			wb_dat_o = '0;
		end
	end

endmodule

//--- src/wb_timer.sv
//----------------------------------------
// Two-channel compare timer, Wishbone slave
// Control, compare and counter per channel
//----------------------------------------

`include "soc_consts.svh"

module wb_timer
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst_n_i,
	// Bus side
	input  logic                       stb_i,
	input  logic                       wb_we_i,
	input  wb_adr_t                    wb_adr_i,
	input  wb_dat_t                    wb_dat_i,
	input  wb_sel_t                    wb_sel_i,
	output wb_dat_t                    wb_dat_o,
	output logic                       ack_o,
	// One line per channel
	output logic [`SOC_NUM_TIMERS-1:0] irq_o
);

	timer_reg_e  reg_sel;
	timer_ctrl_t wr_ctrl;
	logic        bus_acc;
	logic        bus_wr;

	timer_ctrl_t tcr [`SOC_NUM_TIMERS];
	wb_dat_t     cmp [`SOC_NUM_TIMERS];
	wb_dat_t     cnt [`SOC_NUM_TIMERS];

	logic [`SOC_NUM_TIMERS-1:0] hit;
	logic [`SOC_NUM_TIMERS-1:0] wr_tcr;
	logic [`SOC_NUM_TIMERS-1:0] wr_cmp;
	logic [`SOC_NUM_TIMERS-1:0] wr_cnt;

	//----------------------------------------
	// Bus decode
	//----------------------------------------
	assign reg_sel = timer_reg_e'(wb_adr_i[`SOC_REG_MSB:`SOC_REG_LSB]);
	assign wr_ctrl = timer_ctrl_t'(wb_dat_i[$bits(timer_ctrl_t)-1:0]);

	// First strobe cycle only
	assign bus_acc = stb_i & ~ack_o;
	assign bus_wr  = bus_acc & wb_we_i;

	always_comb begin
		wr_tcr = '0;
		wr_cmp = '0;
		wr_cnt = '0;
		if (bus_wr) begin
			case (reg_sel)
				TCR0: wr_tcr[0] = 1'b1;
				CMP0: wr_cmp[0] = 1'b1;
				CNT0: wr_cnt[0] = 1'b1;
				TCR1: wr_tcr[1] = 1'b1;
				CMP1: wr_cmp[1] = 1'b1;
				CNT1: wr_cnt[1] = 1'b1;
				default: ;
			endcase
		end
	end

	// Single-cycle ack
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= bus_acc;
		end
	end

	//----------------------------------------
	// Channels
	//----------------------------------------
	// Running counter reached its compare value
	always_comb begin
		for (int ch = 0; ch < `SOC_NUM_TIMERS; ch++) begin
			hit[ch] = tcr[ch].en && (cnt[ch] == cmp[ch]);
			irq_o[ch] = tcr[ch].trig & tcr[ch].irqen;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int ch = 0; ch < `SOC_NUM_TIMERS; ch++) begin
				tcr[ch] <= '0;
				cmp[ch] <= '0;
				cnt[ch] <= '0;
			end
		end else begin
			for (int ch = 0; ch < `SOC_NUM_TIMERS; ch++) begin
				// Control, only the low byte carries bits
				if (wr_tcr[ch] && wb_sel_i[0]) begin
					tcr[ch].en    <= wr_ctrl.en;
					tcr[ch].ar    <= wr_ctrl.ar;
					tcr[ch].irqen <= wr_ctrl.irqen;
				end else if (hit[ch] && !tcr[ch].ar) begin
					// One-shot stops on match
					tcr[ch].en <= 1'b0;
				end
				// New match wins over a clear in the same cycle
				tcr[ch].trig <= hit[ch] |
					(tcr[ch].trig & ~(wr_tcr[ch] & wb_sel_i[0] & wr_ctrl.trig));

				if (wr_cmp[ch]) begin
					cmp[ch] <= wb_merge(cmp[ch], wb_dat_i, wb_sel_i);
				end

				// Counter, bus load first
				if (wr_cnt[ch]) begin
					cnt[ch] <= wb_merge(cnt[ch], wb_dat_i, wb_sel_i);
				end else if (hit[ch]) begin
					if (tcr[ch].ar) begin
						cnt[ch] <= '0;
					end
				end else if (tcr[ch].en) begin
					cnt[ch] <= cnt[ch] + 32'd1;
				end
			end
		end
	end

	//----------------------------------------
	// Read data, valid with ack
	//----------------------------------------
	always_ff @(posedge clk) begin
		if (bus_acc) begin
			case (reg_sel)
				TCR0: wb_dat_o <= 32'(tcr[0]);
				CMP0: wb_dat_o <= cmp[0];
				CNT0: wb_dat_o <= cnt[0];
				TCR1: wb_dat_o <= 32'(tcr[1]);
				CMP1: wb_dat_o <= cmp[1];
				CNT1: wb_dat_o <= cnt[1];
				default: wb_dat_o <= '0;
			endcase
		end
	end

endmodule

//--- src/wb_gpio.sv
//----------------------------------------
// 32-bit GPIO, Wishbone slave
// Input sync, rising-edge interrupts
//----------------------------------------

`include "soc_consts.svh"

module wb_gpio
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n_i,
	// Bus side
	input  logic        stb_i,
	input  logic        wb_we_i,
	input  wb_adr_t     wb_adr_i,
	input  wb_dat_t     wb_dat_i,
	input  wb_sel_t     wb_sel_i,
	output wb_dat_t     wb_dat_o,
	output logic        ack_o,
	// Pins
	input  logic [31:0] gpio_in_i,
	output logic [31:0] gpio_out_o,
	output logic [31:0] gpio_oe_o,
	output logic        irq_o
);

	gpio_reg_e   reg_sel;
	logic        bus_acc;
	logic        bus_wr;
	logic [31:0] in_meta;
	logic [31:0] in_sync;
	logic [31:0] in_prev;
	logic [31:0] irq_mask;
	logic [31:0] irq_stat;
	logic [31:0] rise;
	logic [31:0] stat_clr;

	assign reg_sel = gpio_reg_e'(wb_adr_i[`SOC_REG_MSB:`SOC_REG_LSB]);
	assign bus_acc = stb_i & ~ack_o;
	assign bus_wr  = bus_acc & wb_we_i;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= bus_acc;
		end
	end

	//----------------------------------------
	// Input synchronizer and edge detect
	//----------------------------------------
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			in_meta <= '0;
			in_sync <= '0;
			in_prev <= '0;
		end else begin
			in_meta <= gpio_in_i;
			in_sync <= in_meta;
			in_prev <= in_sync;
		end
	end

	// Masked low-to-high transitions
	assign rise = in_sync & ~in_prev & irq_mask;

	// Write-1-to-clear, selected bytes only
	assign stat_clr = (bus_wr && reg_sel == GPIO_IRQ_STAT) ?
		wb_merge('0, wb_dat_i, wb_sel_i) : '0;

	//----------------------------------------
	// Registers
	//----------------------------------------
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			gpio_out_o <= '0;
			gpio_oe_o  <= '0;
			irq_mask   <= '0;
			irq_stat   <= '0;
		end else begin
			if (bus_wr) begin
				case (reg_sel)
					GPIO_OUT:      gpio_out_o <= wb_merge(gpio_out_o, wb_dat_i, wb_sel_i);
					GPIO_OE:       gpio_oe_o  <= wb_merge(gpio_oe_o, wb_dat_i, wb_sel_i);
					GPIO_IRQ_MASK: irq_mask   <= wb_merge(irq_mask, wb_dat_i, wb_sel_i);
					default: ;
				endcase
			end
			// A fresh edge beats a clear
			irq_stat <= (irq_stat & ~stat_clr) | rise;
		end
	end

	assign irq_o = |irq_stat;

	// Read data, valid with ack
	always_ff @(posedge clk) begin
		if (bus_acc) begin
			case (reg_sel)
				GPIO_IN:       wb_dat_o <= in_sync;
				GPIO_OUT:      wb_dat_o <= gpio_out_o;
				GPIO_OE:       wb_dat_o <= gpio_oe_o;
				GPIO_IRQ_MASK: wb_dat_o <= irq_mask;
				GPIO_IRQ_STAT: wb_dat_o <= irq_stat;
				default:       wb_dat_o <= '0;
			endcase
		end
	end

endmodule

//--- src/periph_subsys.sv
//----------------------------------------
// Peripheral subsystem top level
// Slave mux, compare timer, GPIO
// Active-low interrupt vector
//----------------------------------------

module periph_subsys
	import soc_bus_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n_i,
	// Wishbone slave port
	input  wb_adr_t     wb_adr_i,
	input  wb_dat_t     wb_dat_i,
	input  wb_sel_t     wb_sel_i,
	input  logic        wb_we_i,
	input  logic        wb_cyc_i,
	input  logic        wb_stb_i,
	output wb_dat_t     wb_dat_o,
	output logic        wb_ack_o,
	// GPIO pins
	input  logic [31:0] gpio_in_i,
	output logic [31:0] gpio_out_o,
	output logic [31:0] gpio_oe_o,
	// Interrupts
	output logic [2:0]  irq_n_o
);

	logic       tmr_stb;
	logic       gpio_stb;
	logic       tmr_ack;
	logic       gpio_ack;
	wb_dat_t    tmr_dat;
	wb_dat_t    gpio_dat;
	logic [1:0] tmr_irq;
	logic       gpio_irq;

	//----------------------------------------
	// Decode and response combining
	//----------------------------------------
	wb_slave_mux slave_mux0 (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.wb_adr_i   (wb_adr_i),
		.wb_cyc_i   (wb_cyc_i),
		.wb_stb_i   (wb_stb_i),
		.tmr_stb_o  (tmr_stb),
		.gpio_stb_o (gpio_stb),
		.tmr_ack_i  (tmr_ack),
		.gpio_ack_i (gpio_ack),
		.tmr_dat_i  (tmr_dat),
		.gpio_dat_i (gpio_dat),
		.wb_dat_o   (wb_dat_o),
		.wb_ack_o   (wb_ack_o)
	);

	//----------------------------------------
	// Peripherals
	//----------------------------------------
	wb_timer timer0 (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.stb_i    (tmr_stb),
		.wb_we_i  (wb_we_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_sel_i (wb_sel_i),
		.wb_dat_o (tmr_dat),
		.ack_o    (tmr_ack),
		.irq_o    (tmr_irq)
	);

	wb_gpio gpio0 (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.stb_i      (gpio_stb),
		.wb_we_i    (wb_we_i),
		.wb_adr_i   (wb_adr_i),
		.wb_dat_i   (wb_dat_i),
		.wb_sel_i   (wb_sel_i),
		.wb_dat_o   (gpio_dat),
		.ack_o      (gpio_ack),
		.gpio_in_i  (gpio_in_i),
		.gpio_out_o (gpio_out_o),
		.gpio_oe_o  (gpio_oe_o),
		.irq_o      (gpio_irq)
	);

	// Slot order kept from the full map, UART slot removed
	assign irq_n_o = {~tmr_irq[1], ~gpio_irq, ~tmr_irq[0]};

endmodule

//--- bench/periph_subsys_assert.sv
//----------------------------------------
// Concurrent checks on the bus handshake
// Interrupt vector state during reset
//----------------------------------------

module periph_subsys_assert (
	input logic       clk,
	input logic       rst_n_i,
	input logic       wb_cyc_i,
	input logic       wb_stb_i,
	input logic       wb_ack_o,
	input logic [2:0] irq_n_o
);

	// Number of failed assertions
	int unsigned fail_count = 0;

	// Ack is a single-cycle pulse
	ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_ack_o |=> !wb_ack_o)
	else begin
		$error("wb_ack_o stayed high for more than one cycle");
		fail_count++;
	end

	// No ack without a strobed cycle just before
	ack_after_req: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
	else begin
		$error("wb_ack_o rose without cyc and stb in the previous cycle");
		fail_count++;
	end

	// All interrupt lines idle while in reset
	irq_idle_in_reset: assert property (@(posedge clk)
		!rst_n_i |-> (irq_n_o == 3'b111))
	else begin
		$error("irq_n_o not all ones during reset");
		fail_count++;
	end

endmodule

bind periph_subsys periph_subsys_assert bus_checks (
	.clk      (clk),
	.rst_n_i  (rst_n_i),
	.wb_cyc_i (wb_cyc_i),
	.wb_stb_i (wb_stb_i),
	.wb_ack_o (wb_ack_o),
	.irq_n_o  (irq_n_o)
);

//--- bench/periph_subsys_tb.sv
//----------------------------------------
// Directed testbench for the peripheral subsystem
// Bus tasks, compare tasks, five tests
//----------------------------------------

`include "soc_consts.svh"

module periph_subsys_tb
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;
();

	localparam int ACK_LIMIT  = 8;
	localparam int POLL_LIMIT = 8;

	logic        clk;
	logic        rst_n_i;
	wb_adr_t     wb_adr_i;
	wb_dat_t     wb_dat_i;
	wb_sel_t     wb_sel_i;
	logic        wb_we_i;
	logic        wb_cyc_i;
	logic        wb_stb_i;
	wb_dat_t     wb_dat_o;
	logic        wb_ack_o;
	logic [31:0] gpio_in_i;
	logic [31:0] gpio_out_o;
	logic [31:0] gpio_oe_o;
	logic [2:0]  irq_n_o;

	int n_checks = 0;
	int n_errors = 0;

	// Register shadows
	wb_dat_t out_model  = '0;
	wb_dat_t oe_model   = '0;
	wb_dat_t cmp0_model = '0;
	wb_dat_t cmp1_model = '0;

	periph_subsys dut (.*);

	always #10 clk = ~clk;

	//----------------------------------------
	// Helpers
	//----------------------------------------
	function automatic wb_adr_t reg_addr(input logic [14:0] base, input logic [2:0] idx);
		wb_adr_t addr;
		addr = '0;
		addr[`SOC_DEC_MSB:`SOC_DEC_LSB] = base;
		addr[`SOC_REG_MSB:`SOC_REG_LSB] = idx;
		return addr;
	endfunction

	// Byte lanes expanded into a bit mask
	function automatic wb_dat_t apply_byte_sel(input wb_dat_t old_val, input wb_dat_t new_val,
			input wb_sel_t sel);
		wb_dat_t mask;
		mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (old_val & ~mask) | (new_val & mask);
	endfunction

	task automatic abort_run(input string reason);
		n_errors++;
		n_errors += dut.bus_checks.fail_count;
		$display("%s", reason);
		$display("Checks run: %0d, errors: %0d", n_checks, n_errors);
		$display("Test failures found");
		$finish;
	endtask

	task automatic check_dat(input string name, input wb_dat_t exp, input wb_dat_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("Error: %s expected 0x%h, got 0x%h", name, exp, act);
		end
	endtask

	task automatic check_irq(input logic [2:0] exp, input logic [2:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("Error: irq_n_o expected 0x%h, got 0x%h", exp, act);
		end
	endtask

	task automatic check_gpio(input string name, input logic [31:0] exp, input logic [31:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("Error: %s expected 0x%h, got 0x%h", name, exp, act);
		end
	endtask

	//----------------------------------------
	// Bus master
	//----------------------------------------
	// Strobe sampled at the first edge and ack seen at the second
	task automatic bus_access(input logic we, input wb_adr_t addr, input wb_dat_t wdata,
			input wb_sel_t sel, output wb_dat_t rdata);
		int waited;
		waited = 0;
		rdata = '0;
		@(posedge clk);
		wb_adr_i <= addr;
		wb_dat_i <= wdata;
		wb_sel_i <= sel;
		wb_we_i  <= we;
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		do begin
			@(posedge clk);
			waited++;
		end while (wb_ack_o !== 1'b1 && waited < ACK_LIMIT);
		if (wb_ack_o !== 1'b1) begin
			abort_run($sformatf("No acknowledge from address 0x%h within %0d cycles",
				addr, ACK_LIMIT));
		end else begin
			n_checks++;
			if (waited != 2) begin
				n_errors++;
				$display("Error: wb_ack_o latency expected 0x2, got 0x%h", waited);
			end
			rdata = wb_dat_o;
			wb_cyc_i <= 1'b0;
			wb_stb_i <= 1'b0;
			wb_we_i  <= 1'b0;
		end
	endtask

	task automatic wb_write(input wb_adr_t addr, input wb_dat_t data, input wb_sel_t sel);
		wb_dat_t unused_rd;
		bus_access(1'b1, addr, data, sel, unused_rd);
	endtask

	task automatic wb_read(input wb_adr_t addr, output wb_dat_t data);
		bus_access(1'b0, addr, '0, 4'hf, data);
	endtask

	task automatic write_random_sel(input wb_adr_t addr, inout wb_dat_t model);
		wb_dat_t data;
		wb_sel_t sel;
		data = $urandom;
		sel = wb_sel_t'($urandom);
		wb_write(addr, data, sel);
		model = apply_byte_sel(model, data, sel);
	endtask

	// Read IN until the synchronizer has caught up
	task automatic wait_gpio_in(input logic [31:0] expected);
		wb_dat_t rd;
		int tries;
		tries = 0;
		do begin
			wb_read(reg_addr(`SOC_GPIO_BASE, GPIO_IN), rd);
			tries++;
		end while (rd !== expected && tries < POLL_LIMIT);
		if (rd !== expected) begin
			abort_run("GPIO input value never showed up in the IN register");
		end
	endtask

	task automatic wait_irq_low(input int bit_idx, input int limit);
		int waited;
		waited = 0;
		while (irq_n_o[bit_idx] !== 1'b0 && waited < limit) begin
			@(posedge clk);
			waited++;
		end
		if (irq_n_o[bit_idx] !== 1'b0) begin
			abort_run($sformatf("Interrupt line %0d did not fall within %0d cycles",
				bit_idx, limit));
		end
	endtask

	//----------------------------------------
	// Tests
	//----------------------------------------
	task automatic test_regs();
		wb_dat_t rd;
		for (int i = 0; i < 6; i++) begin
			write_random_sel(reg_addr(`SOC_GPIO_BASE, GPIO_OUT), out_model);
			write_random_sel(reg_addr(`SOC_GPIO_BASE, GPIO_OE), oe_model);
			write_random_sel(reg_addr(`SOC_TIMER_BASE, CMP0), cmp0_model);
			write_random_sel(reg_addr(`SOC_TIMER_BASE, CMP1), cmp1_model);
			wb_read(reg_addr(`SOC_GPIO_BASE, GPIO_OUT), rd);
			check_dat("OUT", out_model, rd);
			wb_read(reg_addr(`SOC_GPIO_BASE, GPIO_OE), rd);
			check_dat("OE", oe_model, rd);
			wb_read(reg_addr(`SOC_TIMER_BASE, CMP0), rd);
			check_dat("CMP0", cmp0_model, rd);
			wb_read(reg_addr(`SOC_TIMER_BASE, CMP1), rd);
			check_dat("CMP1", cmp1_model, rd);
			check_gpio("gpio_out_o", out_model, gpio_out_o);
			check_gpio("gpio_oe_o", oe_model, gpio_oe_o);
		end
	endtask

	task automatic test_gpio_irq();
		logic [31:0] mask;
		logic [31:0] prev;
		logic [31:0] next;
		logic [31:0] stat;
		wb_dat_t rd;
		mask = $urandom;
		prev = gpio_in_i;
		stat = '0;
		wb_write(reg_addr(`SOC_GPIO_BASE, GPIO_IRQ_MASK), mask, 4'hf);
		for (int i = 0; i < 5; i++) begin
			next = $urandom;
			@(posedge clk);
			gpio_in_i <= next;
			wait_gpio_in(next);
			// Only low-to-high under the mask
			stat = stat | (next & ~prev & mask);
			prev = next;
			wb_read(reg_addr(`SOC_GPIO_BASE, GPIO_IRQ_STAT), rd);
			check_dat("IRQ_STAT", stat, rd);
			check_irq({1'b1, ~(|stat), 1'b1}, irq_n_o);
		end
		wb_write(reg_addr(`SOC_GPIO_BASE, GPIO_IRQ_STAT), 32'hffff_ffff, 4'hf);
		wb_read(reg_addr(`SOC_GPIO_BASE, GPIO_IRQ_STAT), rd);
		check_dat("IRQ_STAT", 32'h0, rd);
		check_irq(3'b111, irq_n_o);
	endtask

	task automatic test_timer_oneshot();
		timer_ctrl_t ctrl;
		wb_dat_t cmp_val;
		wb_dat_t rd;
		cmp_val = 32'd5 + ($urandom % 20);
		cmp0_model = cmp_val;
		wb_write(reg_addr(`SOC_TIMER_BASE, CNT0), 32'h0, 4'hf);
		wb_write(reg_addr(`SOC_TIMER_BASE, CMP0), cmp_val, 4'hf);
		ctrl = '0;
		ctrl.en = 1'b1;
		ctrl.irqen = 1'b1;
		wb_write(reg_addr(`SOC_TIMER_BASE, TCR0), {28'h0, ctrl}, 4'hf);
		wait_irq_low(0, int'(cmp_val) + 10);
		check_irq(3'b110, irq_n_o);
		wb_read(reg_addr(`SOC_TIMER_BASE, CNT0), rd);
		check_dat("CNT0", cmp_val, rd);
		// Stopped on match with trig sticky
		ctrl.en = 1'b0;
		ctrl.trig = 1'b1;
		wb_read(reg_addr(`SOC_TIMER_BASE, TCR0), rd);
		check_dat("TCR0", {28'h0, ctrl}, rd);
		ctrl = '0;
		ctrl.trig = 1'b1;
		wb_write(reg_addr(`SOC_TIMER_BASE, TCR0), {28'h0, ctrl}, 4'hf);
		check_irq(3'b111, irq_n_o);
	endtask

	task automatic test_timer_reload();
		timer_ctrl_t ctrl;
		wb_dat_t cmp_val;
		wb_dat_t rd;
		// Period long enough to clear trig before the next match
		cmp_val = 32'd20 + ($urandom % 12);
		cmp1_model = cmp_val;
		wb_write(reg_addr(`SOC_TIMER_BASE, CNT1), 32'h0, 4'hf);
		wb_write(reg_addr(`SOC_TIMER_BASE, CMP1), cmp_val, 4'hf);
		ctrl = '0;
		ctrl.en = 1'b1;
		ctrl.ar = 1'b1;
		ctrl.irqen = 1'b1;
		wb_write(reg_addr(`SOC_TIMER_BASE, TCR1), {28'h0, ctrl}, 4'hf);
		wait_irq_low(2, int'(cmp_val) + 10);
		check_irq(3'b011, irq_n_o);
		ctrl.trig = 1'b1;
		wb_read(reg_addr(`SOC_TIMER_BASE, TCR1), rd);
		check_dat("TCR1", {28'h0, ctrl}, rd);
		// Clear trig and keep running
		wb_write(reg_addr(`SOC_TIMER_BASE, TCR1), {28'h0, ctrl}, 4'hf);
		check_irq(3'b111, irq_n_o);
		wait_irq_low(2, int'(cmp_val) + 10);
		check_irq(3'b011, irq_n_o);
		wb_read(reg_addr(`SOC_TIMER_BASE, TCR1), rd);
		check_dat("TCR1", {28'h0, ctrl}, rd);
		ctrl = '0;
		ctrl.trig = 1'b1;
		wb_write(reg_addr(`SOC_TIMER_BASE, TCR1), {28'h0, ctrl}, 4'hf);
		check_irq(3'b111, irq_n_o);
	endtask

	task automatic probe_unmapped(input wb_adr_t addr);
		wb_dat_t rd;
		wb_write(addr, 32'hffff_ffff, 4'hf);
		wb_read(addr, rd);
		check_dat("unmapped read data", 32'h0, rd);
	endtask

	task automatic test_unmapped();
		wb_dat_t rd;
		// Low offsets alias real registers but the decode field does not
		// All ones at offset 0 would restart timer 0 if it reached TCR0
		probe_unmapped(32'h0000_0000);
		probe_unmapped(32'h0000_0004);
		probe_unmapped(32'he000_0004);
		probe_unmapped(32'he006_0008);
		wb_read(reg_addr(`SOC_GPIO_BASE, GPIO_OUT), rd);
		check_dat("OUT", out_model, rd);
		wb_read(reg_addr(`SOC_GPIO_BASE, GPIO_OE), rd);
		check_dat("OE", oe_model, rd);
		wb_read(reg_addr(`SOC_TIMER_BASE, CMP0), rd);
		check_dat("CMP0", cmp0_model, rd);
		wb_read(reg_addr(`SOC_TIMER_BASE, CMP1), rd);
		check_dat("CMP1", cmp1_model, rd);
		check_gpio("gpio_out_o", out_model, gpio_out_o);
		check_gpio("gpio_oe_o", oe_model, gpio_oe_o);
		check_irq(3'b111, irq_n_o);
	endtask

	//----------------------------------------
	// Main sequence
	//----------------------------------------
	initial begin
		clk = 1'b0;
		rst_n_i = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		wb_sel_i = '0;
		wb_we_i = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		gpio_in_i = '0;
		void'($urandom(62));
		repeat (16) @(posedge clk);
		rst_n_i <= 1'b1;
		repeat (2) @(posedge clk);
		check_gpio("gpio_out_o", 32'h0, gpio_out_o);
		check_gpio("gpio_oe_o", 32'h0, gpio_oe_o);
		check_irq(3'b111, irq_n_o);
		test_regs();
		test_gpio_irq();
		test_timer_oneshot();
		test_timer_reload();
		test_unmapped();
		repeat (2) @(posedge clk);
		n_errors += dut.bus_checks.fail_count;
		$display("Checks run: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- periph_subsys.f
+incdir+src
src/soc_bus_pkg.sv
src/soc_periph_pkg.sv
src/wb_slave_mux.sv
src/wb_timer.sv
src/wb_gpio.sv
src/periph_subsys.sv
bench/periph_subsys_assert.sv
bench/periph_subsys_tb.sv
